// File: include/cfgLoader_cfg.svh
`ifndef CFGLOADER_CFG_SVH
`define CFGLOADER_CFG_SVH

// clock cycles per serial bit
// simulation value, real use is clock frequency / baud rate
`define CFG_COM_RATE 16

// idle cycles after a byte before the frame is dropped
// must stay above one byte time (10 bits)
`define CFG_TIMEOUT_CYCLES 400

// header ID, sent as 00 then AA then FF
`define CFG_FRAME_ID 24'h00AAFF

// command codes that open a payload phase (bit 7 is the hex flag)
`define CFG_CMD_A 7'd1
`define CFG_CMD_B 7'd2

`endif

// File: hdl/cfgLoaderPkg.sv
`default_nettype none

package cfgLoaderPkg;

    typedef logic [7:0]  byteT;
    typedef logic [3:0]  nibbleT;
    typedef logic [31:0] wordT;
    typedef logic [23:0] frameIdT;
    typedef logic [7:0]  cmdT;       // bit 7 selects ASCII hex payload
    typedef logic [1:0]  wordSlotT;  // byte position inside the word

    // one received UART byte, data valid while strobe is high
    typedef struct packed {
        byteT data;
        logic strobe;
    } rxByteT;

    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxData,
        rxStop
    } rxStateT;

    typedef enum logic [2:0] {
        frIdle,
        frId1,
        frId2,
        frCommand,
        frEval,
        frData
    } frameStateT;

endpackage

`default_nettype wire

// File: hdl/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgLoader_cfg.svh"

module uartRx
    import cfgLoaderPkg::*;
(
    input  logic   CLK,
    input  logic   resetn,
    input  logic   Rx,
    output rxByteT rxByte
);

    localparam int RateW      = $clog2(`CFG_COM_RATE);
    localparam int FullReload = `CFG_COM_RATE - 1;
    localparam int HalfReload = `CFG_COM_RATE / 2 - 1;

    logic [1:0]       rxSync;
    logic             rxBit;
    logic [RateW-1:0] baudCnt;
    logic             baudTick;
    logic [2:0]       bitCnt;
    rxStateT          rxState;
    byteT             shiftReg;
    logic             byteStrobe;

    // two-flop synchronizer, line idles high
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 2'b11;
        end else begin
            rxSync <= {rxSync[0], Rx};
        end
    end

    assign rxBit = rxSync[1];

    // baud timer
    // held at half a period while idle so the first tick lands mid start bit
    assign baudTick = (baudCnt == '0);

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            baudCnt <= '0;
        end else if (rxState == rxIdle) begin
            baudCnt <= RateW'(HalfReload);
        end else if (baudTick) begin
            baudCnt <= RateW'(FullReload);
        end else begin
            baudCnt <= baudCnt - RateW'(1);
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxState    <= rxIdle;
            bitCnt     <= '0;
            byteStrobe <= 1'b0;
        end else begin
            byteStrobe <= 1'b0;
            case (rxState)
                rxIdle: begin
                    if (!rxBit) rxState <= rxStart;  // start edge
                end
                rxStart: begin
                    if (baudTick) begin
                        rxState <= rxData;
                        bitCnt  <= '0;
                    end
                end
                rxData: begin
                    if (baudTick) begin
                        bitCnt <= bitCnt + 3'd1;
                        if (bitCnt == 3'd7) rxState <= rxStop;
                    end
                end
                rxStop: begin
                    // stop level is not checked
                    if (baudTick) begin
                        rxState    <= rxIdle;
                        byteStrobe <= 1'b1;
                    end
                end
                default: rxState <= rxIdle;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge CLK) begin
        if (rxState == rxData && baudTick) shiftReg <= {rxBit, shiftReg[7:1]};
    end

    assign rxByte = '{data: shiftReg, strobe: byteStrobe};

    // stop state is left on the same tick that fires the strobe
    strobeSingle: assert property (
        @(posedge CLK) disable iff (!resetn) rxByte.strobe |=> !rxByte.strobe
    );

endmodule

`default_nettype wire

// File: hdl/frameCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgLoader_cfg.svh"

module frameCtrl
    import cfgLoaderPkg::*;
(
    input  logic   CLK,
    input  logic   resetn,
    input  rxByteT rxByte,
    output cmdT    command,
    output logic   dataPhase
);

    localparam int TimerW      = $clog2(`CFG_TIMEOUT_CYCLES);
    localparam int TimerReload = `CFG_TIMEOUT_CYCLES - 1;

    frameStateT        frameState;
    frameIdT           idReg;
    cmdT               cmdReg;
    logic [TimerW-1:0] idleTimer;
    logic              timedOut;
    logic              frameOk;

    // header ID bytes, first one arrives while still idle
    always_ff @(posedge CLK) begin
        if (rxByte.strobe) begin
            case (frameState)
                frIdle:  idReg[23:16] <= rxByte.data;
                frId1:   idReg[15:8]  <= rxByte.data;
                frId2:   idReg[7:0]   <= rxByte.data;
                default: idReg        <= idReg;
            endcase
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            cmdReg <= '0;
        end else if (rxByte.strobe && frameState == frCommand) begin
            cmdReg <= rxByte.data;
        end
    end

    assign command = cmdReg;

    // only the low seven bits name the command
    assign frameOk = (idReg == `CFG_FRAME_ID)
                  && (cmdReg[6:0] == `CFG_CMD_A || cmdReg[6:0] == `CFG_CMD_B);

    // inactivity timer, restarted by every byte
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            idleTimer <= '0;
        end else if (rxByte.strobe) begin
            idleTimer <= TimerW'(TimerReload);
        end else if (frameState != frIdle && idleTimer != '0) begin
            idleTimer <= idleTimer - TimerW'(1);
        end
    end

    // a byte landing on the last count still counts as activity
    assign timedOut = (frameState != frIdle) && (idleTimer == '0) && !rxByte.strobe;

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            frameState <= frIdle;
        end else if (timedOut) begin
            frameState <= frIdle;
        end else begin
            case (frameState)
                frIdle: begin
                    if (rxByte.strobe) frameState <= frId1;
                end
                frId1: begin
                    if (rxByte.strobe) frameState <= frId2;
                end
                frId2: begin
                    if (rxByte.strobe) frameState <= frCommand;
                end
                frCommand: begin
                    if (rxByte.strobe) frameState <= frEval;
                end
                frEval: begin
                    frameState <= frameOk ? frData : frIdle;
                end
                frData: begin
                    frameState <= frData;  // left only by timeout
                end
                default: frameState <= frIdle;
            endcase
        end
    end

    assign dataPhase = (frameState == frData);

    evalOneCycle: assert property (
        @(posedge CLK) disable iff (!resetn) frameState == frEval |=> frameState != frEval
    );

endmodule

`default_nettype wire

// File: hdl/payloadPacker.sv
`timescale 1ns/1ps
`default_nettype none

module payloadPacker
    import cfgLoaderPkg::*;
(
    input  logic   CLK,
    input  logic   resetn,
    input  rxByteT rxByte,
    input  cmdT    command,
    input  logic   dataPhase,
    output wordT   WriteData,
    output logic   WriteStrobe
);

    logic     hexMode;
    logic     byteIn;
    logic     charValid;
    nibbleT   charNibble;
    logic     highPending;
    nibbleT   highNibble;
    logic     byteReady;
    byteT     newByte;
    wordSlotT wordSlot;
    wordT     wordBuf;

    function automatic logic isHex(input byteT c);
        return c inside {[8'h30:8'h39], [8'h41:8'h46], [8'h61:8'h66]};
    endfunction

    function automatic nibbleT hexNibble(input byteT c);
        // letters of either case: low bits plus nine
        return c[6] ? c[3:0] + 4'd9 : c[3:0];
    endfunction

    assign hexMode    = command[7];
    assign byteIn     = rxByte.strobe && dataPhase;
    assign charValid  = isHex(rxByte.data);
    assign charNibble = hexNibble(rxByte.data);

    // nibble pairing, a bad character starts over with a new high nibble
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            highPending <= 1'b0;
        end else if (!dataPhase) begin
            highPending <= 1'b0;
        end else if (byteIn && hexMode) begin
            if (!charValid) begin
                highPending <= 1'b0;
            end else begin
                highPending <= !highPending;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (byteIn && hexMode && charValid && !highPending) highNibble <= charNibble;
    end

    // one formed byte: a closed hex pair, or any raw byte in binary mode
    assign byteReady = byteIn && (!hexMode || (charValid && highPending));
    assign newByte   = hexMode ? {highNibble, charNibble} : rxByte.data;

    // MSB first, older bytes move up
    always_ff @(posedge CLK) begin
        if (byteReady) wordBuf <= {wordBuf[23:0], newByte};
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            wordSlot    <= '0;
            WriteData   <= '0;
            WriteStrobe <= 1'b0;
        end else begin
            WriteStrobe <= 1'b0;
            if (!dataPhase) begin
                wordSlot <= '0;  // partial word dropped
            end else if (byteReady) begin
                wordSlot <= wordSlot + 2'd1;
                if (wordSlot == 2'd3) begin
                    WriteData   <= {wordBuf[23:0], newByte};
                    WriteStrobe <= 1'b1;
                end
            end
        end
    end

    // words only come out of an accepted frame
    strobeInData: assert property (
        @(posedge CLK) disable iff (!resetn) WriteStrobe |-> (dataPhase || $fell(dataPhase))
    );

endmodule

`default_nettype wire

// File: hdl/cfgLoaderTop.sv
`timescale 1ns/1ps
`default_nettype none

module cfgLoaderTop
    import cfgLoaderPkg::*;
(
    input  logic CLK,
    input  logic resetn,
    input  logic Rx,
    output wordT WriteData,
    output logic WriteStrobe,
    output logic ComActive,
    output cmdT  Command
);

    rxByteT rxByte;  // shared by frame control and packer

    uartRx uartRx_i (
        .CLK    (CLK),
        .resetn (resetn),
        .Rx     (Rx),
        .rxByte (rxByte)
    );

    frameCtrl frameCtrl_i (
        .CLK       (CLK),
        .resetn    (resetn),
        .rxByte    (rxByte),
        .command   (Command),
        .dataPhase (ComActive)
    );

    payloadPacker payloadPacker_i (
        .CLK         (CLK),
        .resetn      (resetn),
        .rxByte      (rxByte),
        .command     (Command),
        .dataPhase   (ComActive),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe)
    );

endmodule

`default_nettype wire

// File: verification/cfgLoaderTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cfgLoader_cfg.svh"

module cfgLoaderTb
    import cfgLoaderPkg::*;
();

    localparam int ByteCycles = 10 * `CFG_COM_RATE;      // start, 8 data, stop
    localparam int IdleBase   = `CFG_TIMEOUT_CYCLES + 40;  // lets any open frame time out

    logic CLK;
    logic resetn;
    logic Rx;
    wordT WriteData;
    logic WriteStrobe;
    logic ComActive;
    cmdT  Command;

    // test records from the stimulus file
    string testName[$];
    int    gapAt[$];
    int    gapLen[$];
    cmdT   expCmd[$];
    logic  expActive[$];
    int    byteCount[$];
    int    wordCount[$];
    byteT  txBytes[$];
    wordT  expWords[$];

    wordT got[$];  // words seen on WriteStrobe
    int   checks = 0;
    int   errors = 0;
    int   cycles = 0;
    int   cycleLimit = 0;
    int   seed;

    cfgLoaderTop cfgLoaderTop_i (
        .CLK         (CLK),
        .resetn      (resetn),
        .Rx          (Rx),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe),
        .ComActive   (ComActive),
        .Command     (Command)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(negedge CLK) begin
        if (WriteStrobe) got.push_back(WriteData);
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic checkWord(input string what, input wordT exp, input wordT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic checkCmd(input string what, input cmdT exp, input cmdT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s command: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic checkActive(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s activity: expected %b, actual %b", what, exp, act);
        end
    endtask

    // 8N1, LSB first, called on a falling edge
    task automatic sendByte(input byteT b);
        int i;
        Rx = 1'b0;
        repeat (`CFG_COM_RATE) @(negedge CLK);
        for (i = 0; i < 8; i++) begin
            Rx = b[i];
            repeat (`CFG_COM_RATE) @(negedge CLK);
        end
        Rx = 1'b1;
        repeat (`CFG_COM_RATE) @(negedge CLK);
    endtask

    function automatic bit readStimulus();
        int    fd;
        int    n;
        int    i;
        int    gA;
        int    gL;
        int    cmd;
        int    act;
        int    nB;
        int    nW;
        int    value;
        string line;
        string name;
        fd = $fopen("verification/cfgLoaderStimulus.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %h %d %d %d", name, gA, gL, cmd, act, nB, nW);
                    if (n == 7) begin
                        testName.push_back(name);
                        gapAt.push_back(gA);
                        gapLen.push_back(gL);
                        expCmd.push_back(cmdT'(cmd));
                        expActive.push_back(act[0]);
                        byteCount.push_back(nB);
                        wordCount.push_back(nW);
                        for (i = 0; i < nB; i++) begin
                            n = $fscanf(fd, "%h", value);
                            txBytes.push_back(byteT'(value));
                        end
                        for (i = 0; i < nW; i++) begin
                            n = $fscanf(fd, "%h", value);
                            expWords.push_back(wordT'(value));
                        end
                    end
                end
            end
            $fclose(fd);
            return testName.size() > 0;
        end
    endfunction

    task automatic runTest(input int t, input int byteBase, input int wordBase);
        int errBefore;
        int idle;
        int i;
        errBefore = errors;
        got.delete();
        for (i = 0; i < byteCount[t]; i++) begin
            sendByte(txBytes[byteBase + i]);
            if (gapLen[t] > 0 && i + 1 == gapAt[t]) begin
                repeat (gapLen[t]) @(negedge CLK);
                if (gapLen[t] > `CFG_TIMEOUT_CYCLES) begin
                    checkActive({testName[t], " after gap"}, 1'b0, ComActive);
                end
            end
        end
        // last word lands just after the final stop bit
        while (got.size() < wordCount[t]) @(negedge CLK);
        repeat (4) @(negedge CLK);
        checkActive(testName[t], expActive[t], ComActive);
        checkCmd(testName[t], expCmd[t], Command);
        idle = IdleBase + ($random(seed) & 32'h3F);
        repeat (idle) @(negedge CLK);  // stray words would show up here
        if (got.size() != wordCount[t]) begin
            checks++;
            errors++;
            $display("MISMATCH %s word count: expected %0d, actual %0d",
                     testName[t], wordCount[t], got.size());
        end else begin
            for (i = 0; i < wordCount[t]; i++) begin
                checkWord($sformatf("%s word %0d", testName[t], i), expWords[wordBase + i], got[i]);
            end
        end
        $display("test %s finished, %0d error(s)", testName[t], errors - errBefore);
    endtask

    initial begin
        int t;
        int byteBase;
        int wordBase;
        int gapSum;
        Rx     = 1'b1;
        resetn = 1'b0;
        seed   = 32'h4b784859;
        if (!readStimulus()) begin
            $display("no test records could be read from verification/cfgLoaderStimulus.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            gapSum = 0;
            foreach (gapLen[k]) gapSum += gapLen[k];
            // bytes on the line, inner gaps, idle between records, reset and margin
            cycleLimit = txBytes.size() * ByteCycles + gapSum
                       + testName.size() * (IdleBase + 64 + 8) + 2000;
            repeat (10) @(posedge CLK);
            @(negedge CLK);
            resetn = 1'b1;
            repeat (2) @(negedge CLK);
            checkWord("reset data", '0, WriteData);
            checkCmd("reset", '0, Command);
            checkActive("reset", 1'b0, ComActive);
            checkActive("reset strobe", 1'b0, WriteStrobe);
            $display("test reset finished, %0d error(s)", errors);
            byteBase = 0;
            wordBase = 0;
            for (t = 0; t < testName.size(); t++) begin
                runTest(t, byteBase, wordBase);
                byteBase += byteCount[t];
                wordBase += wordCount[t];
            end
            $display("%0d tests, %0d checks, %0d errors", testName.size() + 1, checks, errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hdl/cfgLoaderPkg.sv
hdl/uartRx.sv
hdl/frameCtrl.sv
hdl/payloadPacker.sv
hdl/cfgLoaderTop.sv
verification/cfgLoaderTb.sv

// File: Makefile
TOP = cfgLoaderTb
RTL = hdl/cfgLoaderPkg.sv hdl/uartRx.sv hdl/frameCtrl.sv hdl/payloadPacker.sv hdl/cfgLoaderTop.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Iinclude --top-module cfgLoaderTop $(RTL)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/cfgLoaderStimulus.txt
# record line: name gapAt gapLen command active byteCount wordCount
# then byteCount bytes to send and wordCount expected words, all hex
binFrame 0 0 01 1 12 2
00 AA FF 01 12 34 56 78 9A BC DE F0
12345678 9ABCDEF0

hexFrame 0 0 82 1 22 2
00 AA FF 82 31 32 61 42 33 63 34 44
35 78 36 37 38 39 65 46 30 31
12AB3C4D 6789EF01

wrongId 0 0 01 0 7 0
00 AB FF 01 11 22 33

badCmd 0 0 03 0 7 0
00 AA FF 03 11 22 33

timeout 10 600 02 1 18 2
00 AA FF 01 A1 A2 A3 A4 B1 B2
00 AA FF 02 C1 C2 C3 C4
A1A2A3A4 C1C2C3C4
